//--- include/id_consts.svh
//////////////////////////////////////////////////
// Instruction ID bookkeeping constants
// Sizes of the ID space, retire ports and counts
//////////////////////////////////////////////////
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// Number of rolling instruction IDs
`define MAX_IDS 8

// Width of one ID, log2 of MAX_IDS
`define ID_W 3

// Number of retire ports on the commit side
`define COMMIT_PORTS 2

// Completion count width, holds branch + store + system + retire ports
`define COUNT_W 3

// Fetched IDs waiting for decode, one slot per rolling ID
`define FIFO_DEPTH `MAX_IDS

`endif

//--- source/id_pkg.sv
//////////////////////////////////////////////////
// ID bookkeeping types
// Shared by the allocator, status tracker and top
//////////////////////////////////////////////////
`include "id_consts.svh"

package id_pkg;

    // Rolling instruction ID
    typedef logic [`ID_W-1:0] id_t;

    // Number of completions seen in one cycle
    typedef logic [`COUNT_W-1:0] count_t;

    //////////////////////////////////////////////////
    // Issue stage view

    // Instruction in the issue stage
    //   stage_valid  an instruction occupies the stage
    //   issued       it leaves the stage this cycle
    //   uses_rd      it writes a destination register
    typedef struct packed {
        id_t  id;
        logic stage_valid;
        logic issued;
        logic uses_rd;
    } issue_packet_t;

endpackage

//--- source/toggle_memory.sv
//////////////////////////////////////////////////
// Toggle memory, one bit per instruction ID
// Write inverts a bit, read is asynchronous
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "id_consts.svh"

module toggle_memory
    import id_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic toggle_i,
    input  id_t  toggle_id_i,

    input  id_t  read_id_i,
    output logic read_data_o
);

    // One parity bit per ID
    logic [`MAX_IDS-1:0] bits_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            bits_q <= '0;
        end else if (toggle_i) begin
            bits_q[toggle_id_i] <= ~bits_q[toggle_id_i];
        end
    end

    // Lookup sees the state after the previous edge
    assign read_data_o = bits_q[read_id_i];

endmodule

//--- source/id_fifo.sv
//////////////////////////////////////////////////
// In-order FIFO of fetched instruction IDs
// Circular buffer with a synchronous clear
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "id_consts.svh"

module id_fifo
    import id_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic clear_i,

    input  logic push_i,
    input  id_t  data_i,

    input  logic pop_i,
    output id_t  data_o,
    output logic valid_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    id_t              mem_q [`FIFO_DEPTH];
    ptr_t             rd_ptr_q;
    ptr_t             wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic do_push;
    logic do_pop;

    // Clear takes priority over a push in the same cycle
    assign do_push = push_i & ~clear_i;
    assign do_pop  = pop_i & valid_o;

    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    //////////////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst | clear_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign valid_o = (count_q != '0);

endmodule

//--- source/id_allocator.sv
//////////////////////////////////////////////////
// Instruction ID allocator
// Next-ID and fetch-ID counters with fetch FIFO
//////////////////////////////////////////////////
`timescale 1ns/10ps

module id_allocator
    import id_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic fetch_flush_i,

    // ID issue to fetch
    input  logic pc_id_assigned_i,
    output id_t  pc_id_o,
    output id_t  pc_id_next_o,

    // Fetch stage
    input  logic fetch_complete_i,
    output id_t  fetch_id_o,

    // Decode stage
    input  logic decode_advance_i,
    output id_t  decode_id_o,
    output logic decode_id_valid_o
);

    // Next ID keeps counting through a flush
    assign pc_id_next_o = pc_id_o + id_t'(pc_id_assigned_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id_o <= '0;
        end else begin
            pc_id_o <= pc_id_next_o;
        end
    end

    // Fetch ID restarts from the next ID after a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_id_o <= '0;
        end else if (fetch_flush_i) begin
            fetch_id_o <= pc_id_o;
        end else begin
            fetch_id_o <= fetch_id_o + id_t'(fetch_complete_i);
        end
    end

    //////////////////////////////////////////////////
    // IDs fetched but not yet decoded
    id_fifo u_fetch_fifo (
        .clk     (clk),
        .rst     (rst),
        .clear_i (fetch_flush_i),
        .push_i  (fetch_complete_i),
        .data_i  (fetch_id_o),
        .pop_i   (decode_advance_i),
        .data_o  (decode_id_o),
        .valid_o (decode_id_valid_o)
    );

endmodule

//--- source/id_status.sv
//////////////////////////////////////////////////
// ID status tracker built from toggle memories
// Availability, source in-use and completion count
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "id_consts.svh"

module id_status
    import id_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     fetch_flush_i,
    input  id_t                      pc_id_next_i,

    // Decode and issue
    input  logic                     decode_advance_i,
    input  id_t                      decode_id_i,
    input  issue_packet_t            issue_i,

    // Source lookups
    input  id_t                      rs1_id_i,
    input  id_t                      rs2_id_i,

    // Completion sources
    input  logic                     branch_complete_i,
    input  id_t                      branch_id_i,
    input  logic                     store_complete_i,
    input  id_t                      store_id_i,
    input  logic                     system_complete_i,
    input  logic                     exception_rd_i,
    input  id_t                      system_id_i,
    input  logic [`COMMIT_PORTS-1:0] retired_i,
    input  id_t  [`COMMIT_PORTS-1:0] retire_ids_i,

    output logic                     pc_id_available_o,
    output logic                     rs1_id_inuse_o,
    output logic                     rs2_id_inuse_o,
    output count_t                   retire_inc_o
);

    logic decoded_st;
    logic decode_done_st;
    logic issued_st;
    logic issued_rs1_st;
    logic issued_rs2_st;
    logic branch_st;
    logic store_st;
    logic system_st;
    logic exc_rd_rs1_st;
    logic exc_rd_rs2_st;

    logic [`COMMIT_PORTS-1:0] retired_st;
    logic [`COMMIT_PORTS-1:0] retired_rs1_st;
    logic [`COMMIT_PORTS-1:0] retired_rs2_st;

    logic   issued_rd;
    logic   id_free;
    count_t complete_count;

    // Issued instructions that will write the register file
    assign issued_rd = issue_i.issued & issue_i.uses_rd;

    //////////////////////////////////////////////////
    // Decoded, then issued or dropped by a flush
    toggle_memory u_decode_mem (
        .clk(clk), .rst(rst),
        .toggle_i(decode_advance_i & ~fetch_flush_i), .toggle_id_i(decode_id_i),
        .read_id_i(pc_id_next_i), .read_data_o(decoded_st)
    );
    toggle_memory u_decode_done_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issue_i.issued | (fetch_flush_i & issue_i.stage_valid)),
        .toggle_id_i(issue_i.id),
        .read_id_i(pc_id_next_i), .read_data_o(decode_done_st)
    );

    //////////////////////////////////////////////////
    // In flight after issue, looked up by next ID
    toggle_memory u_issued_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issue_i.issued), .toggle_id_i(issue_i.id),
        .read_id_i(pc_id_next_i), .read_data_o(issued_st)
    );
    toggle_memory u_branch_mem (
        .clk(clk), .rst(rst),
        .toggle_i(branch_complete_i), .toggle_id_i(branch_id_i),
        .read_id_i(pc_id_next_i), .read_data_o(branch_st)
    );
    toggle_memory u_store_mem (
        .clk(clk), .rst(rst),
        .toggle_i(store_complete_i), .toggle_id_i(store_id_i),
        .read_id_i(pc_id_next_i), .read_data_o(store_st)
    );
    toggle_memory u_system_mem (
        .clk(clk), .rst(rst),
        .toggle_i(system_complete_i), .toggle_id_i(system_id_i),
        .read_id_i(pc_id_next_i), .read_data_o(system_st)
    );

    //////////////////////////////////////////////////
    // Destination writers, looked up by source IDs
    toggle_memory u_issued_rs1_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issued_rd), .toggle_id_i(issue_i.id),
        .read_id_i(rs1_id_i), .read_data_o(issued_rs1_st)
    );
    toggle_memory u_issued_rs2_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issued_rd), .toggle_id_i(issue_i.id),
        .read_id_i(rs2_id_i), .read_data_o(issued_rs2_st)
    );
    toggle_memory u_exc_rd_rs1_mem (
        .clk(clk), .rst(rst),
        .toggle_i(exception_rd_i), .toggle_id_i(system_id_i),
        .read_id_i(rs1_id_i), .read_data_o(exc_rd_rs1_st)
    );
    toggle_memory u_exc_rd_rs2_mem (
        .clk(clk), .rst(rst),
        .toggle_i(exception_rd_i), .toggle_id_i(system_id_i),
        .read_id_i(rs2_id_i), .read_data_o(exc_rd_rs2_st)
    );

    // Each retire port gets its own memory on every read port
    for (genvar p = 0; p < `COMMIT_PORTS; p++) begin : g_retire
        toggle_memory u_retire_mem (
            .clk(clk), .rst(rst),
            .toggle_i(retired_i[p]), .toggle_id_i(retire_ids_i[p]),
            .read_id_i(pc_id_next_i), .read_data_o(retired_st[p])
        );
        toggle_memory u_retire_rs1_mem (
            .clk(clk), .rst(rst),
            .toggle_i(retired_i[p]), .toggle_id_i(retire_ids_i[p]),
            .read_id_i(rs1_id_i), .read_data_o(retired_rs1_st[p])
        );
        toggle_memory u_retire_rs2_mem (
            .clk(clk), .rst(rst),
            .toggle_i(retired_i[p]), .toggle_id_i(retire_ids_i[p]),
            .read_id_i(rs2_id_i), .read_data_o(retired_rs2_st[p])
        );
    end

    //////////////////////////////////////////////////
    // Parity checks

    // Free when both the decode pair and the in-flight set are balanced
    assign id_free = ~(decoded_st ^ decode_done_st) &
                     ~(issued_st ^ branch_st ^ store_st ^ system_st ^ (^retired_st));

    // Only destination writers sit in the register-to-ID table
    assign rs1_id_inuse_o = issued_rs1_st ^ exc_rd_rs1_st ^ (^retired_rs1_st);
    assign rs2_id_inuse_o = issued_rs2_st ^ exc_rd_rs2_st ^ (^retired_rs2_st);

    // Status of the next ID, ready together with the new pc_id
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id_available_o <= 1'b1;
        end else begin
            pc_id_available_o <= id_free;
        end
    end

    // Completions this cycle
    always_comb begin
        complete_count = count_t'(branch_complete_i) + count_t'(store_complete_i) +
                         count_t'(system_complete_i);
        for (int p = 0; p < `COMMIT_PORTS; p++) begin
            complete_count += count_t'(retired_i[p]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_inc_o <= '0;
        end else begin
            retire_inc_o <= complete_count;
        end
    end

endmodule

//--- source/id_management.sv
//////////////////////////////////////////////////
// Instruction ID management, top level
// Connects the ID allocator and status tracker
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "id_consts.svh"

module id_management
    import id_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     fetch_flush_i,

    // ID issue
    output id_t                      pc_id_o,
    output logic                     pc_id_available_o,
    input  logic                     pc_id_assigned_i,

    // Fetch stage
    output id_t                      fetch_id_o,
    input  logic                     fetch_complete_i,

    // Decode stage
    input  logic                     decode_advance_i,
    output id_t                      decode_id_o,
    output logic                     decode_id_valid_o,

    // Issue stage
    input  issue_packet_t            issue_i,
    input  id_t                      rs1_id_i,
    input  id_t                      rs2_id_i,
    output logic                     rs1_id_inuse_o,
    output logic                     rs2_id_inuse_o,

    // Completion
    input  logic                     branch_complete_i,
    input  id_t                      branch_id_i,
    input  logic                     store_complete_i,
    input  id_t                      store_id_i,
    input  logic                     system_complete_i,
    input  logic                     exception_rd_i,
    input  id_t                      system_id_i,
    input  logic [`COMMIT_PORTS-1:0] retired_i,
    input  id_t  [`COMMIT_PORTS-1:0] retire_ids_i,

    output count_t                   retire_inc_o
);

    // ID that pc_id_o takes at the next edge
    id_t pc_id_next;

    id_allocator u_allocator (
        .clk               (clk),
        .rst               (rst),
        .fetch_flush_i     (fetch_flush_i),
        .pc_id_assigned_i  (pc_id_assigned_i),
        .pc_id_o           (pc_id_o),
        .pc_id_next_o      (pc_id_next),
        .fetch_complete_i  (fetch_complete_i),
        .fetch_id_o        (fetch_id_o),
        .decode_advance_i  (decode_advance_i),
        .decode_id_o       (decode_id_o),
        .decode_id_valid_o (decode_id_valid_o)
    );

    id_status u_status (
        .clk               (clk),
        .rst               (rst),
        .fetch_flush_i     (fetch_flush_i),
        .pc_id_next_i      (pc_id_next),
        .decode_advance_i  (decode_advance_i),
        .decode_id_i       (decode_id_o),
        .issue_i           (issue_i),
        .rs1_id_i          (rs1_id_i),
        .rs2_id_i          (rs2_id_i),
        .branch_complete_i (branch_complete_i),
        .branch_id_i       (branch_id_i),
        .store_complete_i  (store_complete_i),
        .store_id_i        (store_id_i),
        .system_complete_i (system_complete_i),
        .exception_rd_i    (exception_rd_i),
        .system_id_i       (system_id_i),
        .retired_i         (retired_i),
        .retire_ids_i      (retire_ids_i),
        .pc_id_available_o (pc_id_available_o),
        .rs1_id_inuse_o    (rs1_id_inuse_o),
        .rs2_id_inuse_o    (rs2_id_inuse_o),
        .retire_inc_o      (retire_inc_o)
    );

endmodule

//--- test/id_management_checker.sv
//////////////////////////////////////////////////
// Handshake assertions for ID management
// Bound to the top level by the testbench
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "id_consts.svh"

module id_management_checker (
    input logic clk,
    input logic rst,
    input logic pc_id_assigned_i,
    input logic pc_id_available_o,
    input logic decode_advance_i,
    input logic decode_id_valid_o
);

    // Fetch only takes an ID that is free
    assign_needs_available: assert property (
        @(posedge clk) disable iff (rst) pc_id_assigned_i |-> pc_id_available_o
    ) else $error("ID assigned while pc_id_available_o was low");

    // Decode only pops a valid FIFO head
    advance_needs_valid: assert property (
        @(posedge clk) disable iff (rst) decode_advance_i |-> decode_id_valid_o
    ) else $error("decode advanced while decode_id_valid_o was low");

endmodule

//--- test/id_management_tb.sv
//////////////////////////////////////////////////
// Testbench for instruction ID management
// Directed tests against a per-ID reference model
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "id_consts.svh"

module id_management_tb
    import id_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 16;
    // Cycle budget per test, roughly twice the expected length
    localparam int TEST_CYCLES    = 40 + 30 + 40 + 100 + 50;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 20;

    logic                     clk;
    logic                     rst;
    logic                     fetch_flush_i;
    id_t                      pc_id_o;
    logic                     pc_id_available_o;
    logic                     pc_id_assigned_i;
    id_t                      fetch_id_o;
    logic                     fetch_complete_i;
    logic                     decode_advance_i;
    id_t                      decode_id_o;
    logic                     decode_id_valid_o;
    issue_packet_t            issue_i;
    id_t                      rs1_id_i;
    id_t                      rs2_id_i;
    logic                     rs1_id_inuse_o;
    logic                     rs2_id_inuse_o;
    logic                     branch_complete_i;
    id_t                      branch_id_i;
    logic                     store_complete_i;
    id_t                      store_id_i;
    logic                     system_complete_i;
    logic                     exception_rd_i;
    id_t                      system_id_i;
    logic [`COMMIT_PORTS-1:0] retired_i;
    id_t  [`COMMIT_PORTS-1:0] retire_ids_i;
    count_t                   retire_inc_o;

    // Reference model, one entry per ID
    logic decoded_m    [`MAX_IDS];
    logic inflight_m   [`MAX_IDS];
    logic rd_pending_m [`MAX_IDS];
    id_t  exp_pc;
    id_t  exp_fetch;
    id_t  fetch_q [$];
    logic [7:0] lfsr_q = 8'd90;

    id_management u_dut (.*);

    bind id_management id_management_checker u_checker (
        .clk(clk), .rst(rst),
        .pc_id_assigned_i(pc_id_assigned_i), .pc_id_available_o(pc_id_available_o),
        .decode_advance_i(decode_advance_i), .decode_id_valid_o(decode_id_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("FAIL: see errors above");
        $fatal(1, "timeout: the tests did not finish in %0d cycles", TIMEOUT_CYCLES);
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic tick();
        @(negedge clk);
    endtask

    task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("error: time %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic free_model(input id_t id);
        return !decoded_m[id] && !inflight_m[id];
    endfunction

    // Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            value  = (value << 1) | lfsr_q[0];
        end
    endtask

    task automatic assign_id();
        while (!pc_id_available_o) begin
            tick();
        end
        check_eq("pc_id_o", pc_id_o, exp_pc);
        check_eq("pc_id_available_o", pc_id_available_o, free_model(exp_pc));
        pc_id_assigned_i = 1'b1;
        tick();
        pc_id_assigned_i = 1'b0;
        exp_pc++;
    endtask

    task automatic fetch_one();
        fetch_complete_i = 1'b1;
        tick();
        fetch_complete_i = 1'b0;
        fetch_q.push_back(exp_fetch);
        exp_fetch++;
    endtask

    task automatic decode_one(output id_t id);
        check_eq("decode_id_valid_o", decode_id_valid_o, 1'b1);
        check_eq("decode_id_o", decode_id_o, fetch_q[0]);
        id = fetch_q.pop_front();
        decode_advance_i = 1'b1;
        tick();
        decode_advance_i = 1'b0;
        decoded_m[id] = 1'b1;
    endtask

    task automatic issue_one(input id_t id, input logic rd);
        issue_i.id          = id;
        issue_i.stage_valid = 1'b1;
        issue_i.issued      = 1'b1;
        issue_i.uses_rd     = rd;
        tick();
        issue_i         = '0;
        decoded_m[id]    = 1'b0;
        inflight_m[id]   = 1'b1;
        rd_pending_m[id] = rd;
    endtask

    // Source 0 branch, 1 store, 2 system, 3 and up a retire port
    task automatic complete_one(input id_t id, input int src);
        case (src)
            0: begin branch_complete_i = 1'b1; branch_id_i = id; end
            1: begin store_complete_i  = 1'b1; store_id_i  = id; end
            2: begin system_complete_i = 1'b1; system_id_i = id; end
            default: begin
                retired_i[src - 3]    = 1'b1;
                retire_ids_i[src - 3] = id;
            end
        endcase
        tick();
        branch_complete_i = 1'b0;
        store_complete_i  = 1'b0;
        system_complete_i = 1'b0;
        retired_i         = '0;
        inflight_m[id]    = 1'b0;
        if (src >= 3) begin
            rd_pending_m[id] = 1'b0;
        end
    endtask

    task automatic check_inuse(input id_t id);
        rs1_id_i = id;
        rs2_id_i = id;
        #10;
        check_eq("rs1_id_inuse_o", rs1_id_inuse_o, rd_pending_m[id]);
        check_eq("rs2_id_inuse_o", rs2_id_inuse_o, rd_pending_m[id]);
        tick();
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset();
        check_eq("pc_id_o", pc_id_o, 0);
        check_eq("pc_id_available_o", pc_id_available_o, 1);
        check_eq("decode_id_valid_o", decode_id_valid_o, 0);
        check_eq("retire_inc_o", retire_inc_o, 0);
    endtask

    task automatic test_fetch_order();
        id_t id;
        repeat (4) assign_id();
        repeat (4) fetch_one();
        repeat (4) begin
            decode_one(id);
            issue_one(id, 1'b0);
            complete_one(id, 1);
        end
        check_eq("decode_id_valid_o", decode_id_valid_o, 0);
    endtask

    task automatic test_flush();
        id_t id;
        repeat (2) assign_id();
        repeat (2) fetch_one();
        check_eq("decode_id_valid_o", decode_id_valid_o, 1);
        fetch_flush_i = 1'b1;
        tick();
        fetch_flush_i = 1'b0;
        fetch_q.delete();
        exp_fetch = exp_pc;
        check_eq("decode_id_valid_o", decode_id_valid_o, 0);
        check_eq("fetch_id_o", fetch_id_o, exp_pc);
        assign_id();
        fetch_one();
        decode_one(id);
        issue_one(id, 1'b0);
        complete_one(id, 0);
    endtask

    task automatic test_source_inuse();
        id_t id;
        assign_id();
        fetch_one();
        decode_one(id);
        issue_one(id, 1'b1);
        check_inuse(id);
        repeat (2) tick();
        check_inuse(id);
        complete_one(id, 3);
        check_inuse(id);
        // No destination register, never in use
        assign_id();
        fetch_one();
        decode_one(id);
        issue_one(id, 1'b0);
        check_inuse(id);
        complete_one(id, 1);
        check_inuse(id);
    endtask

    task automatic test_exhaustion();
        id_t id;
        id_t tmp;
        id_t order [`MAX_IDS];
        int  j;
        int  src;
        repeat (`MAX_IDS) begin
            assign_id();
            fetch_one();
            decode_one(id);
            issue_one(id, 1'b0);
        end
        tick();
        check_eq("pc_id_o", pc_id_o, exp_pc);
        check_eq("pc_id_available_o", pc_id_available_o, 0);
        for (int i = 0; i < `MAX_IDS; i++) begin
            order[i] = id_t'(i);
        end
        for (int i = `MAX_IDS - 1; i > 0; i--) begin
            draw_bits(3, j);
            j        = j % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < `MAX_IDS; i++) begin
            draw_bits(3, src);
            complete_one(order[i], src % (3 + `COMMIT_PORTS));
            tick();
            check_eq("pc_id_available_o", pc_id_available_o, free_model(exp_pc));
        end
        check_eq("pc_id_available_o", pc_id_available_o, 1);
    endtask

    task automatic test_completion_count();
        logic [4:0] combo;
        for (int c = 0; c < 32; c++) begin
            combo             = c[4:0];
            branch_complete_i = combo[0];
            store_complete_i  = combo[1];
            system_complete_i = combo[2];
            retired_i         = combo[4:3];
            tick();
            check_eq("retire_inc_o", retire_inc_o, $countones(combo));
        end
        branch_complete_i = 1'b0;
        store_complete_i  = 1'b0;
        system_complete_i = 1'b0;
        retired_i         = '0;
        tick();
        check_eq("retire_inc_o", retire_inc_o, 0);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        fetch_flush_i = 1'b0;
        pc_id_assigned_i = 1'b0;
        fetch_complete_i = 1'b0;
        decode_advance_i = 1'b0;
        issue_i = '0;
        rs1_id_i = '0;
        rs2_id_i = '0;
        branch_complete_i = 1'b0;
        branch_id_i = '0;
        store_complete_i = 1'b0;
        store_id_i = '0;
        system_complete_i = 1'b0;
        exception_rd_i = 1'b0;
        system_id_i = '0;
        retired_i = '0;
        retire_ids_i = '0;
        exp_pc = '0;
        exp_fetch = '0;
        for (int i = 0; i < `MAX_IDS; i++) begin
            decoded_m[i] = 1'b0;
            inflight_m[i] = 1'b0;
            rd_pending_m[i] = 1'b0;
        end
        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
        test_reset();
        test_fetch_order();
        test_flush();
        test_source_inuse();
        test_exhaustion();
        test_completion_count();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
source/id_pkg.sv
source/toggle_memory.sv
source/id_fifo.sv
source/id_allocator.sv
source/id_status.sv
source/id_management.sv
test/id_management_checker.sv
test/id_management_tb.sv

//--- Bender.yml
package:
  name: id_management

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/id_pkg.sv
      - source/toggle_memory.sv
      - source/id_fifo.sv
      - source/id_allocator.sv
      - source/id_status.sv
      - source/id_management.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/id_management_checker.sv
      - test/id_management_tb.sv
